// File: src.f
source/portalPkg.sv
source/portalFifo.sv
source/burstSequencer.sv
source/portalReadPath.sv
source/portalWritePath.sv
source/portalTop.sv
tests/portalTop_assert.sv
tests/portalTop_tb.sv

// File: Bender.yml
package:
  name: portal_bridge

sources:
  - files:
      - source/portalPkg.sv
      - source/portalFifo.sv
      - source/burstSequencer.sv
      - source/portalReadPath.sv
      - source/portalWritePath.sv
      - source/portalTop.sv
  - target: test
    files:
      - tests/portalTop_assert.sv
      - tests/portalTop_tb.sv

// File: tests/portalTop_tb.sv
`timescale 1ns/1ps

module portalTop_tb;

  import portalPkg::*;

  localparam int FifoDepth = 2;
  localparam int Timeout = 1000;
  localparam int DrainTimeout = 20000;

  logic CLK;
  logic RST_N;
  axiAddrT ar;
  logic arValid;
  logic arReady;
  axiAddrT aw;
  logic awValid;
  logic awReady;
  axiWDataT w;
  logic wValid;
  logic wReady;
  axiRDataT r;
  logic rValid;
  logic rReady;
  axiBRespT b;
  logic bValid;
  logic bReady;
  dataT req;
  logic reqLast;
  logic reqValid;
  logic reqReady;
  dataT ind;
  logic indValid;
  logic indReady;
  logic irq;

  integer seed;
  string curTest;
  int errors = 0;
  int checks = 0;
  int testsRun = 0;
  int testErrStart;
  logic stress = 1'b0;   // Random back-pressure on rReady, bReady, reqReady
  logic tbIntrEn;
  dataT nextInd;         // Word a pop returns when no indication is queued yet
  axiRDataT expR[$];
  axiWDataT expReq[$];
  axiBRespT expB[$];
  dataT indQ[$];
  axiRDataT nextR;
  axiWDataT nextReq;
  axiBRespT nextB;

  portalTop #(.FifoDepth(FifoDepth)) portalTop_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic int randomBelow(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Expected read word from the address and the state seen by the bridge
  function automatic dataT expectedRead(input logic [12:0] addr, input logic enable,
                                        input logic pending, input dataT indWord,
                                        input logic reqRdy);
    logic [4:0] off;
    off = addr[4:0];
    if (addr[11:5] == 7'd0) begin
      case (off)
        5'h00: return {31'd0, pending & enable};
        5'h08: return 32'd1;
        5'h0C: return {31'd0, pending};
        5'h10: return addr[12] ? 32'd6 : 32'd5;
        5'h14: return 32'd2;
        default: return 32'h005A05A0;
      endcase
    end
    if (!addr[12])   // Indication data page
      return (off == 5'h00) ? indWord : (off == 5'h04) ? {31'd0, pending} : 32'd0;
    return (off == 5'h04) ? {31'd0, reqRdy} : 32'd0;
  endfunction

  task automatic abortOnTimeout(input string what);
    $display("Timeout waiting for %s in test %s", what, curTest);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic sendAr(input axiAddrT a);
    int t;
    @(negedge CLK);
    ar = a;
    arValid = 1'b1;
    t = 0;
    do begin
      @(posedge CLK);
      t++;
    end while (!arReady && t < Timeout);
    if (!arReady)
      abortOnTimeout("AR handshake");
    @(negedge CLK);
    arValid = 1'b0;
  endtask

  task automatic sendAw(input axiAddrT a);
    int t;
    @(negedge CLK);
    aw = a;
    awValid = 1'b1;
    t = 0;
    do begin
      @(posedge CLK);
      t++;
    end while (!awReady && t < Timeout);
    if (!awReady)
      abortOnTimeout("AW handshake");
    @(negedge CLK);
    awValid = 1'b0;
  endtask

  task automatic sendW(input dataT words[$], input int beats);
    int i;
    int t;
    for (i = 0; i < beats; i++) begin
      @(negedge CLK);
      w.data = words[i];
      w.last = i == beats - 1;
      wValid = 1'b1;
      t = 0;
      do begin
        @(posedge CLK);
        t++;
      end while (!wReady && t < Timeout);
      if (!wReady)
        abortOnTimeout("W handshake");
    end
    @(negedge CLK);
    wValid = 1'b0;
  endtask

  task automatic readBurst(input logic [12:0] addr, input int len, input idT id);
    int i;
    logic [12:0] beatAddr;
    axiRDataT e;
    axiAddrT a;
    for (i = 0; i <= len; i++) begin
      beatAddr = {addr[12:5], addr[4:0] + 5'(i * 4)};   // Wraps inside the page
      e.data = expectedRead(beatAddr, tbIntrEn, indQ.size() != 0,
                            (indQ.size() != 0) ? indQ[0] : nextInd, reqReady);
      e.id = id;
      e.last = i == len;
      expR.push_back(e);
    end
    a.addr = addr;
    a.id = id;
    a.len = 4'(len);
    sendAr(a);
  endtask

  task automatic writeBurst(input logic [12:0] addr, input int len, input idT id,
                            input dataT words[$]);
    int i;
    logic [4:0] off;
    axiWDataT e;
    axiBRespT eb;
    axiAddrT a;
    for (i = 0; i <= len; i++) begin
      off = addr[4:0] + 5'(i * 4);
      if (addr[12] && addr[11:5] != 7'd0) begin
        e.data = words[i];
        e.last = off != 5'h00;
        expReq.push_back(e);
      end
      if (addr[11:5] == 7'd0 && off == 5'h04)
        tbIntrEn = words[i][0];
    end
    eb.id = id;
    eb.resp = 2'b00;
    expB.push_back(eb);
    a.addr = addr;
    a.id = id;
    a.len = 4'(len);
    fork
      sendAw(a);
      sendW(words, len + 1);
    join
  endtask

  task automatic waitIdle();
    int t;
    t = 0;
    while ((expR.size() != 0 || expReq.size() != 0 || expB.size() != 0)
           && t < DrainTimeout) begin
      @(negedge CLK);
      t++;
    end
    if (expR.size() != 0 || expReq.size() != 0 || expB.size() != 0)
      abortOnTimeout("outstanding responses");
  endtask

  task automatic waitIrq(input logic level);
    int t;
    t = 0;
    while (irq !== level && t < Timeout) begin
      @(negedge CLK);
      t++;
    end
    checks++;
    if (irq !== level) begin
      errors++;
      $display("[ERROR] %s: irq expected %b actual %b", curTest, level, irq);
    end
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testErrStart = errors;
  endtask

  task automatic finishTest();
    waitIdle();
    testsRun++;
    $display("Test %s finished with %0d errors", curTest, errors - testErrStart);
  endtask

  task automatic controlIdentityTest();
    startTest("controlIdentity");
    readBurst(13'h0000, 5, 6'h11);
    readBurst(13'h1000, 5, 6'h22);
    finishTest();
  endtask

  task automatic requestStreamTest();
    dataT words[$];
    int i;
    startTest("requestStream");
    for (i = 0; i < 4; i++)
      words.push_back($random(seed));
    writeBurst(13'h1020, 3, 6'h15, words);
    finishTest();
  endtask

  task automatic indicationPopTest();
    int i;
    startTest("indicationPop");
    nextInd = $random(seed);
    readBurst(13'h0020, 0, 6'h07);
    for (i = 0; i < 8; i++) begin
      @(negedge CLK);
      if (rValid) begin
        errors++;
        $display("Read of the empty indication stream returned in test %s", curTest);
      end
    end
    indQ.push_back(nextInd);
    waitIdle();
    readBurst(13'h0024, 0, 6'h08);
    finishTest();
  endtask

  task automatic interruptTest();
    dataT words[$];
    startTest("interrupt");
    words.push_back(32'd1);
    writeBurst(13'h0004, 0, 6'h30, words);
    waitIdle();
    indQ.push_back($random(seed));
    waitIrq(1'b1);
    readBurst(13'h0000, 0, 6'h31);
    waitIdle();
    words[0] = 32'd0;
    writeBurst(13'h0004, 0, 6'h32, words);
    waitIdle();
    waitIrq(1'b0);
    if (!indValid) begin
      errors++;
      $display("Indication left the stream while it should still wait");
    end
    readBurst(13'h0000, 3, 6'h33);   // Waiting flag now seen without interrupt
    readBurst(13'h0020, 0, 6'h34);
    finishTest();
  endtask

  task automatic backPressureTest();
    int n;
    int i;
    int len;
    dataT words[$];
    logic [12:0] addr;
    startTest("backPressure");
    stress = 1'b1;
    for (n = 0; n < 24; n++) begin
      words.delete();
      len = randomBelow(4);
      for (i = 0; i <= len; i++)
        words.push_back($random(seed));
      case (randomBelow(5))
        0: begin
          addr = {1'(randomBelow(2)), 7'd0, 5'(randomBelow(8) * 4)};
          readBurst(addr, randomBelow(8), idT'(randomBelow(64)));
        end
        1: readBurst(13'h0024, randomBelow(7), idT'(randomBelow(64)));   // Never reaches 0
        2: writeBurst({8'h81, 5'(randomBelow(8) * 4)}, len, idT'(randomBelow(64)), words);
        3: writeBurst({1'(randomBelow(2)), 12'h004}, 0, idT'(randomBelow(64)), words);
        default: writeBurst(13'h0040, len, idT'(randomBelow(64)), words);
      endcase
    end
    waitIdle();
    stress = 1'b0;
    finishTest();
  endtask

  // Ready lines for R, B and the request stream
  initial begin
    rReady = 1'b1;
    bReady = 1'b1;
    reqReady = 1'b1;
    forever begin
      @(negedge CLK);
      rReady = !stress || randomBelow(3) != 0;
      bReady = !stress || randomBelow(3) != 0;
      reqReady = !stress || randomBelow(3) != 0;
    end
  end

  // Indication stream source fed from indQ
  initial begin
    ind = '0;
    indValid = 1'b0;
    forever begin
      @(posedge CLK);
      if (indValid && indReady)
        void'(indQ.pop_front());
      @(negedge CLK);
      indValid = indQ.size() != 0;
      if (indQ.size() != 0)
        ind = indQ[0];
    end
  end

  always @(posedge CLK) begin
    if (RST_N && rValid && rReady) begin
      checks++;
      if (expR.size() == 0) begin
        errors++;
        $display("R beat arrived with no read outstanding in test %s", curTest);
      end else begin
        nextR = expR.pop_front();
        if (r !== nextR) begin
          errors++;
          $display("[ERROR] %s: R expected data %h id %h last %b, actual data %h id %h last %b",
                   curTest, nextR.data, nextR.id, nextR.last, r.data, r.id, r.last);
        end
      end
    end
    if (RST_N && reqValid && reqReady) begin
      checks++;
      if (expReq.size() == 0) begin
        errors++;
        $display("Request word left the bridge with no write for it in test %s", curTest);
      end else begin
        nextReq = expReq.pop_front();
        if (req !== nextReq.data || reqLast !== nextReq.last) begin
          errors++;
          $display("[ERROR] %s: req expected %h last %b, actual %h last %b",
                   curTest, nextReq.data, nextReq.last, req, reqLast);
        end
      end
    end
    if (RST_N && bValid && bReady) begin
      checks++;
      if (expB.size() == 0) begin
        errors++;
        $display("B response arrived with no write outstanding in test %s", curTest);
      end else begin
        nextB = expB.pop_front();
        if (b !== nextB) begin
          errors++;
          $display("[ERROR] %s: B expected id %h resp %b, actual id %h resp %b",
                   curTest, nextB.id, nextB.resp, b.id, b.resp);
        end
      end
    end
  end

  initial begin
    seed = 5;
    curTest = "reset";
    tbIntrEn = 1'b0;
    nextInd = '0;
    RST_N = 1'b0;
    ar = '0;
    arValid = 1'b0;
    aw = '0;
    awValid = 1'b0;
    w = '0;
    wValid = 1'b0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST_N = 1'b1;
    controlIdentityTest();
    requestStreamTest();
    indicationPopTest();
    interruptTest();
    backPressureTest();
    $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
             testsRun, checks, errors, portalTop_inst.handshakeChecks.assertFails);
    if (errors == 0 && portalTop_inst.handshakeChecks.assertFails == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: tests/portalTop_assert.sv
`timescale 1ns/1ps

module portalTop_assert (
  input logic                CLK,
  input logic                RST_N,
  input portalPkg::axiRDataT r,
  input logic                rValid,
  input logic                rReady,
  input portalPkg::axiBRespT b,
  input logic                bValid,
  input logic                bReady,
  input portalPkg::dataT     req,
  input logic                reqLast,
  input logic                reqValid,
  input logic                reqReady,
  input portalPkg::beatT     wrBeat,
  input logic                wrBeatValid,
  input logic                wrBeatReady,
  input logic                irq
);

  int assertFails = 0;
  logic enableSeen;   // Enable as last written by a control beat

  // The write word sits on req while its beat executes
  always_ff @(posedge CLK) begin
    if (!RST_N)
      enableSeen <= 1'b0;
    else if (wrBeatValid && wrBeatReady && wrBeat.isCtrl && wrBeat.offset == 5'h04)
      enableSeen <= req[0];
  end

  rHold: assert property (@(posedge CLK) disable iff (!RST_N)
    rValid && !rReady |=> rValid && $stable(r))
  else begin
    assertFails++;
    $error("R payload changed or valid dropped before its handshake");
  end

  bHold: assert property (@(posedge CLK) disable iff (!RST_N)
    bValid && !bReady |=> bValid && $stable(b))
  else begin
    assertFails++;
    $error("B payload changed or valid dropped before its handshake");
  end

  reqHold: assert property (@(posedge CLK) disable iff (!RST_N)
    reqValid && !reqReady |=> reqValid && $stable(req) && $stable(reqLast))
  else begin
    assertFails++;
    $error("Request payload changed or valid dropped before its handshake");
  end

  // Interrupt only with the enable set
  irqGated: assert property (@(posedge CLK) disable iff (!RST_N)
    !enableSeen |-> !irq)
  else begin
    assertFails++;
    $error("irq high while the interrupt enable is clear");
  end

  resetQuiet: assert property (@(posedge CLK)
    !RST_N ##1 !RST_N |-> !rValid && !bValid && !reqValid)
  else begin
    assertFails++;
    $error("Output valid high during reset");
  end

endmodule

bind portalTop portalTop_assert handshakeChecks (
  .CLK(CLK),
  .RST_N(RST_N),
  .r(r),
  .rValid(rValid),
  .rReady(rReady),
  .b(b),
  .bValid(bValid),
  .bReady(bReady),
  .req(req),
  .reqLast(reqLast),
  .reqValid(reqValid),
  .reqReady(reqReady),
  .wrBeat(wrBeat),
  .wrBeatValid(wrBeatValid),
  .wrBeatReady(wrBeatReady),
  .irq(irq)
);

// File: source/portalTop.sv
`timescale 1ns/1ps

module portalTop #(
  parameter int FifoDepth = 2
) (
  input  logic                CLK,
  input  logic                RST_N,
  input  portalPkg::axiAddrT  ar,
  input  logic                arValid,
  output logic                arReady,
  input  portalPkg::axiAddrT  aw,
  input  logic                awValid,
  output logic                awReady,
  input  portalPkg::axiWDataT w,
  input  logic                wValid,
  output logic                wReady,
  output portalPkg::axiRDataT r,
  output logic                rValid,
  input  logic                rReady,
  output portalPkg::axiBRespT b,
  output logic                bValid,
  input  logic                bReady,
  output portalPkg::dataT     req,
  output logic                reqLast,
  output logic                reqValid,
  input  logic                reqReady,
  input  portalPkg::dataT     ind,
  input  logic                indValid,
  output logic                indReady,
  output logic                irq
);

  import portalPkg::*;

  burstReqT rdBurst;
  burstReqT wrBurst;
  logic rdBurstValid;
  logic rdBurstReady;
  logic wrBurstValid;
  logic wrBurstReady;
  beatT rdBeat;
  beatT wrBeat;
  logic rdBeatValid;
  logic rdBeatReady;
  logic wrBeatValid;
  logic wrBeatReady;
  logic indWaiting;
  logic intrEnable;

  // Portal on bit 12, control page when bits 11:5 are clear
  function automatic burstReqT decodeAddr(axiAddrT a);
    burstReqT d;
    d.portal = portalSelE'(a.addr[12]);
    d.isCtrl = a.addr[11:5] == '0;
    d.offset = a.addr[4:0];
    d.count = beatCountT'(a.len) + 1'b1;
    d.id = a.id;
    return d;
  endfunction

  portalFifo #(.FifoDepth(FifoDepth), .entryT(burstReqT)) arFifo (
    .CLK(CLK), .RST_N(RST_N),
    .inData(decodeAddr(ar)), .inValid(arValid), .inReady(arReady),
    .outData(rdBurst), .outValid(rdBurstValid), .outReady(rdBurstReady)
  );

  portalFifo #(.FifoDepth(FifoDepth), .entryT(burstReqT)) awFifo (
    .CLK(CLK), .RST_N(RST_N),
    .inData(decodeAddr(aw)), .inValid(awValid), .inReady(awReady),
    .outData(wrBurst), .outValid(wrBurstValid), .outReady(wrBurstReady)
  );

  burstSequencer rdSeq (
    .CLK(CLK), .RST_N(RST_N),
    .burst(rdBurst), .burstValid(rdBurstValid), .burstReady(rdBurstReady),
    .beat(rdBeat), .beatValid(rdBeatValid), .beatReady(rdBeatReady)
  );

  burstSequencer wrSeq (
    .CLK(CLK), .RST_N(RST_N),
    .burst(wrBurst), .burstValid(wrBurstValid), .burstReady(wrBurstReady),
    .beat(wrBeat), .beatValid(wrBeatValid), .beatReady(wrBeatReady)
  );

  portalReadPath #(.FifoDepth(FifoDepth)) readPath (
    .CLK(CLK), .RST_N(RST_N),
    .beat(rdBeat), .beatValid(rdBeatValid), .beatReady(rdBeatReady),
    .intrEnable(intrEnable), .reqReadyIn(reqReady),
    .ind(ind), .indValid(indValid), .indReady(indReady), .indWaiting(indWaiting),
    .r(r), .rValid(rValid), .rReady(rReady)
  );

  portalWritePath #(.FifoDepth(FifoDepth)) writePath (
    .CLK(CLK), .RST_N(RST_N),
    .beat(wrBeat), .beatValid(wrBeatValid), .beatReady(wrBeatReady),
    .w(w), .wValid(wValid), .wReady(wReady),
    .indWaiting(indWaiting), .intrEnable(intrEnable),
    .req(req), .reqLast(reqLast), .reqValid(reqValid), .reqReady(reqReady),
    .b(b), .bValid(bValid), .bReady(bReady)
  );

  assign irq = indWaiting && intrEnable;

endmodule

// File: source/portalWritePath.sv
`timescale 1ns/1ps

module portalWritePath #(
  parameter int FifoDepth = 2
) (
  input  logic                CLK,
  input  logic                RST_N,
  input  portalPkg::beatT     beat,
  input  logic                beatValid,
  output logic                beatReady,
  input  portalPkg::axiWDataT w,
  input  logic                wValid,
  output logic                wReady,
  input  logic                indWaiting,
  output logic                intrEnable,
  output portalPkg::dataT     req,
  output logic                reqLast,
  output logic                reqValid,
  input  logic                reqReady,
  output portalPkg::axiBRespT b,
  output logic                bValid,
  input  logic                bReady
);

  import portalPkg::*;

  dataT wordOut;
  logic dataValid;
  logic bInReady;
  logic isReq;
  logic canGo;
  logic execute;
  axiBRespT bResp;

  portalFifo #(.FifoDepth(FifoDepth), .entryT(dataT)) dataFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .inData(w.data),
    .inValid(wValid),
    .inReady(wReady),
    .outData(wordOut),
    .outValid(dataValid),
    .outReady(execute)
  );

  assign isReq = !beat.isCtrl && (beat.portal == requestPortal);
  // Last beat also needs room for its B response
  assign canGo = beatValid && dataValid && (!beat.last || bInReady);
  assign execute = canGo && (!isReq || reqReady);
  assign beatReady = execute;

  assign req = wordOut;
  assign reqLast = beat.offset != '0;
  assign reqValid = canGo && isReq;

  always_ff @(posedge CLK) begin
    if (!RST_N)
      intrEnable <= 1'b0;
    else if (execute && beat.isCtrl && (beat.offset == portalPkg::intrEnable))
      intrEnable <= wordOut[0];
  end

  assign bResp = '{id: beat.id, resp: RespOkay};

  portalFifo #(.FifoDepth(FifoDepth), .entryT(axiBRespT)) bFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .inData(bResp),
    .inValid(execute && beat.last),
    .inReady(bInReady),
    .outData(b),
    .outValid(bValid),
    .outReady(bReady)
  );

endmodule

// File: source/portalReadPath.sv
`timescale 1ns/1ps

module portalReadPath #(
  parameter int FifoDepth = 2
) (
  input  logic                CLK,
  input  logic                RST_N,
  input  portalPkg::beatT     beat,
  input  logic                beatValid,
  output logic                beatReady,
  input  logic                intrEnable,
  input  logic                reqReadyIn,
  input  portalPkg::dataT     ind,
  input  logic                indValid,
  output logic                indReady,
  output logic                indWaiting,
  output portalPkg::axiRDataT r,
  output logic                rValid,
  input  logic                rReady
);

  import portalPkg::*;

  beatT beatQ;
  logic stageValid;
  logic isPop;
  logic respReady;
  logic execute;
  dataT word;
  axiRDataT resp;

  assign indWaiting = indValid;
  assign isPop = !beatQ.isCtrl && (beatQ.portal == indicationPortal) && (beatQ.offset == 5'h00);
  assign execute = stageValid && respReady && (!isPop || indValid);
  assign indReady = stageValid && isPop && respReady;
  assign beatReady = !stageValid || execute;

  always_ff @(posedge CLK) begin
    if (!RST_N)
      stageValid <= 1'b0;
    else if (beatReady)
      stageValid <= beatValid;
  end

  always_ff @(posedge CLK) begin
    if (beatValid && beatReady)
      beatQ <= beat;
  end

  always_comb begin
    word = '0;
    if (beatQ.isCtrl) begin
      case (beatQ.offset)
        intrStatus:  word = {31'd0, indWaiting && intrEnable};   // Pending interrupt
        numTiles:    word = NumTiles;
        queueStatus: word = {31'd0, indWaiting};
        portalId:    word = (beatQ.portal == requestPortal) ? ReqPortalId : IndPortalId;
        numPortals:  word = NumPortals;
        default:     word = CtrlDefault;
      endcase
    end else if (beatQ.portal == indicationPortal) begin
      if (beatQ.offset == 5'h00)
        word = ind;
      else if (beatQ.offset == 5'h04)
        word = {31'd0, indWaiting};
    end else if (beatQ.offset == 5'h04) begin
      word = {31'd0, reqReadyIn};   // Request stream can take a word
    end
  end

  assign resp = '{data: word, id: beatQ.id, last: beatQ.last};

  portalFifo #(.FifoDepth(FifoDepth), .entryT(axiRDataT)) respFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .inData(resp),
    .inValid(execute),
    .inReady(respReady),
    .outData(r),
    .outValid(rValid),
    .outReady(rReady)
  );

endmodule

// File: source/burstSequencer.sv
`timescale 1ns/1ps

module burstSequencer (
  input  logic                CLK,
  input  logic                RST_N,
  input  portalPkg::burstReqT burst,
  input  logic                burstValid,
  output logic                burstReady,
  output portalPkg::beatT     beat,
  output logic                beatValid,
  input  logic                beatReady
);

  import portalPkg::*;

  burstReqT cur;   // Offset and count advance with each beat
  logic active;
  logic takeBurst;
  logic takeBeat;

  assign takeBurst = burstValid && burstReady;
  assign takeBeat = beatValid && beatReady;

  // Next burst only once the final beat is gone
  assign burstReady = !active;
  assign beatValid = active;

  always_comb begin
    beat.portal = cur.portal;
    beat.isCtrl = cur.isCtrl;
    beat.offset = cur.offset;
    beat.id = cur.id;
    beat.last = cur.count == beatCountT'(1);
  end

  always_ff @(posedge CLK) begin
    if (!RST_N)
      active <= 1'b0;
    else if (takeBurst)
      active <= 1'b1;
    else if (takeBeat && beat.last)
      active <= 1'b0;
  end

  always_ff @(posedge CLK) begin
    if (takeBurst) begin
      cur <= burst;
    end else if (takeBeat) begin
      cur.offset <= cur.offset + BeatStride;   // Wraps inside the page
      cur.count <= cur.count - 1'b1;
    end
  end

endmodule

// File: source/portalFifo.sv
`timescale 1ns/1ps

module portalFifo #(
  parameter int FifoDepth = 2,
  parameter type entryT = logic
) (
  input  logic  CLK,
  input  logic  RST_N,
  input  entryT inData,
  input  logic  inValid,
  output logic  inReady,
  output entryT outData,
  output logic  outValid,
  input  logic  outReady
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntW = $clog2(FifoDepth + 1);

  entryT mem [FifoDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic running;   // Low through reset, keeps inReady down
  logic push;
  logic pop;

  function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = inValid && inReady;
  assign pop = outValid && outReady;
  assign inReady = running && (count != CntW'(FifoDepth));
  assign outValid = count != '0;
  assign outData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      running <= 1'b0;
    end else begin
      running <= 1'b1;
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (push)
      mem[wrPtr] <= inData;
  end

endmodule

// File: source/portalPkg.sv
package portalPkg;

  typedef logic [31:0] dataT;
  typedef logic [5:0]  idT;
  typedef logic [4:0]  offsetT;
  typedef logic [4:0]  beatCountT;   // 1 to 16

  typedef enum logic {
    indicationPortal,
    requestPortal
  } portalSelE;

  typedef enum logic [4:0] {
    intrStatus  = 5'h00,
    intrEnable  = 5'h04,
    numTiles    = 5'h08,
    queueStatus = 5'h0C,
    portalId    = 5'h10,
    numPortals  = 5'h14
  } ctrlRegE;

  typedef struct packed {
    logic [12:0] addr;
    idT          id;
    logic [3:0]  len;
  } axiAddrT;

  typedef struct packed {
    dataT data;
    logic last;
  } axiWDataT;

  typedef struct packed {
    dataT data;
    idT   id;
    logic last;
  } axiRDataT;

  typedef struct packed {
    idT         id;
    logic [1:0] resp;
  } axiBRespT;

  typedef struct packed {
    portalSelE portal;
    logic      isCtrl;
    offsetT    offset;   // Start offset within the page
    beatCountT count;
    idT        id;
  } burstReqT;

  typedef struct packed {
    portalSelE portal;
    logic      isCtrl;
    offsetT    offset;
    idT        id;
    logic      last;
  } beatT;

  localparam dataT CtrlDefault = 32'h005A05A0;
  localparam dataT NumTiles = 32'd1;
  localparam dataT NumPortals = 32'd2;
  localparam dataT IndPortalId = 32'd5;
  localparam dataT ReqPortalId = 32'd6;
  localparam offsetT BeatStride = 5'd4;
  localparam logic [1:0] RespOkay = 2'b00;

endpackage
